/* rtl/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and address width
`define WORD_SIZE 16

`define REG_COUNT 4
`define REG_ADDR_BITS 2

// address of the first fetch
`define PC_RESET `WORD_SIZE'h0000

`endif

/* rtl/cpuPkg.sv */
package cpuPkg;

    // opcodes
    localparam logic [3:0] opBne   = 4'd0;
    localparam logic [3:0] opBeq   = 4'd1;
    localparam logic [3:0] opBgz   = 4'd2;
    localparam logic [3:0] opBlz   = 4'd3;
    localparam logic [3:0] opAdi   = 4'd4;
    localparam logic [3:0] opOri   = 4'd5;
    localparam logic [3:0] opLhi   = 4'd6;
    localparam logic [3:0] opLwd   = 4'd7;
    localparam logic [3:0] opSwd   = 4'd8;
    localparam logic [3:0] opJmp   = 4'd9;
    localparam logic [3:0] opJal   = 4'd10;
    localparam logic [3:0] opRtype = 4'd15;

    // R-type function codes
    localparam logic [5:0] fnAdd = 6'd0;
    localparam logic [5:0] fnSub = 6'd1;
    localparam logic [5:0] fnAnd = 6'd2;
    localparam logic [5:0] fnOrr = 6'd3;
    localparam logic [5:0] fnNot = 6'd4;
    localparam logic [5:0] fnTcp = 6'd5;
    localparam logic [5:0] fnShl = 6'd6;
    localparam logic [5:0] fnShr = 6'd7;
    localparam logic [5:0] fnJpr = 6'd25;
    localparam logic [5:0] fnJrl = 6'd26;
    localparam logic [5:0] fnWwd = 6'd28;
    localparam logic [5:0] fnHlt = 6'd29;

    // low eight match the R-type function codes, branches follow opcode order
    localparam logic [3:0] aluOpAdd = 4'd0;
    localparam logic [3:0] aluOpSub = 4'd1;
    localparam logic [3:0] aluOpAnd = 4'd2;
    localparam logic [3:0] aluOpOr  = 4'd3;
    localparam logic [3:0] aluOpNot = 4'd4;
    localparam logic [3:0] aluOpTcp = 4'd5;
    localparam logic [3:0] aluOpShl = 4'd6;
    localparam logic [3:0] aluOpShr = 4'd7;
    localparam logic [3:0] aluOpBne = 4'd8;
    localparam logic [3:0] aluOpBeq = 4'd9;
    localparam logic [3:0] aluOpBgz = 4'd10;
    localparam logic [3:0] aluOpBlz = 4'd11;

    typedef struct packed {
        logic [3:0] opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        logic [5:0] func;
    } rView;

    typedef struct packed {
        logic [3:0] opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [7:0] imm;
    } iView;

    typedef struct packed {
        logic [3:0]  opcode;
        logic [11:0] target;
    } jView;

    typedef union packed {
        rView r;
        iView i;
        jView j;
    } instrWord;

endpackage

/* rtl/registerFile.sv */
`include "cpu_config.svh"

module registerFile (
    input  logic                      Clk,
    input  logic                      rstN,
    input  logic [`REG_ADDR_BITS-1:0] readAddr1,
    input  logic [`REG_ADDR_BITS-1:0] readAddr2,
    input  logic [`REG_ADDR_BITS-1:0] writeAddr,
    input  logic [`WORD_SIZE-1:0]     writeData,
    input  logic                      writeEn,
    output logic [`WORD_SIZE-1:0]     readData1,
    output logic [`WORD_SIZE-1:0]     readData2
);

    logic [`WORD_SIZE-1:0] regs [`REG_COUNT];

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // WB write is visible to ID in the same cycle
    assign readData1 = (writeEn && writeAddr == readAddr1) ? writeData : regs[readAddr1];
    assign readData2 = (writeEn && writeAddr == readAddr2) ? writeData : regs[readAddr2];

endmodule

/* rtl/alu.sv */
`include "cpu_config.svh"

module alu import cpuPkg::*; (
    input  logic [`WORD_SIZE-1:0] a,
    input  logic [`WORD_SIZE-1:0] b,
    input  logic [3:0]            op,
    output logic [`WORD_SIZE-1:0] result,
    output logic                  branchTaken
);

    always_comb begin
        result = '0;
        branchTaken = 1'b0;
        case (op)
            aluOpAdd: result = a + b;
            aluOpSub: result = a - b;
            aluOpAnd: result = a & b;
            aluOpOr:  result = a | b;
            aluOpNot: result = ~a;
            aluOpTcp: result = ~a + 1'b1;
            aluOpShl: result = a << 1;
            // shift right keeps the sign
            aluOpShr: result = {a[`WORD_SIZE-1], a[`WORD_SIZE-1:1]};
            aluOpBne: branchTaken = (a != b);
            aluOpBeq: branchTaken = (a == b);
            aluOpBgz: branchTaken = !a[`WORD_SIZE-1] && (a != '0);
            aluOpBlz: branchTaken = a[`WORD_SIZE-1];
            default: ;
        endcase
    end

endmodule

/* rtl/hazardUnit.sv */
`include "cpu_config.svh"

module hazardUnit (
    input  logic [`REG_ADDR_BITS-1:0] idRs,
    input  logic [`REG_ADDR_BITS-1:0] idRt,
    input  logic                      useRs,
    input  logic                      useRt,
    input  logic [`REG_ADDR_BITS-1:0] exRs,
    input  logic [`REG_ADDR_BITS-1:0] exRt,
    input  logic [`REG_ADDR_BITS-1:0] exRd,
    input  logic                      exMemRead,
    input  logic                      exIsJumpR,
    input  logic [`REG_ADDR_BITS-1:0] memRd,
    input  logic                      memRegWrite,
    input  logic [`REG_ADDR_BITS-1:0] wbRd,
    input  logic                      wbRegWrite,
    output logic [1:0]                forwardA,
    output logic [1:0]                forwardB,
    output logic                      stall
);

    logic idReadsExRd;

    // 1 takes EX/MEM, 2 takes MEM/WB, the younger producer wins
    function automatic logic [1:0] fwdSel(input logic [`REG_ADDR_BITS-1:0] src,
                                          input logic [`REG_ADDR_BITS-1:0] mRd,
                                          input logic mWrite,
                                          input logic [`REG_ADDR_BITS-1:0] wRd,
                                          input logic wWrite);
        if (mWrite && mRd == src) begin
            return 2'd1;
        end
        return (wWrite && wRd == src) ? 2'd2 : 2'd0;
    endfunction

    assign forwardA = fwdSel(exRs, memRd, memRegWrite, wbRd, wbRegWrite);
    assign forwardB = fwdSel(exRt, memRd, memRegWrite, wbRd, wbRegWrite);

    assign idReadsExRd = (useRs && idRs == exRd) || (useRt && idRt == exRd);
    // hold ID behind a load or register jump that writes one of its sources
    assign stall = idReadsExRd && (exMemRead || exIsJumpR);

    fwdAValid: assert final (forwardA != 2'd3);

endmodule

/* rtl/instrDecoder.sv */
module instrDecoder import cpuPkg::*; (
    input  instrWord instr,
    output logic     regDst,
    output logic     isJumpI,
    output logic     isJumpR,
    output logic     isAlu,
    output logic     aluSrc,
    output logic     isBranch,
    output logic     memRead,
    output logic     memWrite,
    output logic     memToReg,
    output logic     regWrite,
    output logic     wwd,
    output logic     isHalt,
    output logic     useRs,
    output logic     useRt
);

    always_comb begin
        {regDst, isJumpI, isJumpR, isAlu, aluSrc, isBranch, memRead} = '0;
        {memWrite, memToReg, regWrite, wwd, isHalt, useRs, useRt} = '0;
        case (instr.r.opcode)
            opBne, opBeq: begin
                isBranch = 1'b1;
                useRs = 1'b1;
                useRt = 1'b1;
            end
            opBgz, opBlz: begin
                isBranch = 1'b1;
                useRs = 1'b1;
            end
            opAdi, opOri, opLhi: begin
                aluSrc = 1'b1;
                regWrite = 1'b1;
                // LHI ignores rs
                useRs = (instr.i.opcode != opLhi);
            end
            opLwd: begin
                aluSrc = 1'b1;
                memRead = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
                useRs = 1'b1;
            end
            opSwd: begin
                aluSrc = 1'b1;
                memWrite = 1'b1;
                useRs = 1'b1;
                useRt = 1'b1;
            end
            opJmp, opJal: begin
                isJumpI = 1'b1;
                regWrite = (instr.j.opcode == opJal);
            end
            opRtype: begin
                case (instr.r.func)
                    fnAdd, fnSub, fnAnd, fnOrr, fnNot, fnTcp, fnShl, fnShr: begin
                        regDst = 1'b1;
                        isAlu = 1'b1;
                        regWrite = 1'b1;
                        useRs = 1'b1;
                        // unary ops read rs only
                        useRt = (instr.r.func < fnNot);
                    end
                    fnWwd: begin
                        wwd = 1'b1;
                        useRs = 1'b1;
                    end
                    fnJpr, fnJrl: begin
                        isJumpR = 1'b1;
                        regWrite = (instr.r.func == fnJrl);
                        useRs = 1'b1;
                    end
                    fnHlt: isHalt = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

/* rtl/datapath.sv */
`include "cpu_config.svh"

module datapath import cpuPkg::*; (
    input  logic                  Clk,
    input  logic                  rstN,
    output logic                  readM1,
    output logic [`WORD_SIZE-1:0] address1,
    input  logic [`WORD_SIZE-1:0] data1,
    output logic                  readM2,
    output logic                  writeM2,
    output logic [`WORD_SIZE-1:0] address2,
    output logic [`WORD_SIZE-1:0] writeData,
    input  logic [`WORD_SIZE-1:0] readData,
    input  logic                  regDst,
    input  logic                  isJumpI,
    input  logic                  isJumpR,
    input  logic                  isAlu,
    input  logic                  aluSrc,
    input  logic                  isBranch,
    input  logic                  memRead,
    input  logic                  memWrite,
    input  logic                  memToReg,
    input  logic                  regWrite,
    input  logic                  wwd,
    input  logic                  isHalt,
    input  logic                  useRs,
    input  logic                  useRt,
    output instrWord              idInstr,
    output logic                  halted,
    output logic [`WORD_SIZE-1:0] numInst,
    output logic [`WORD_SIZE-1:0] outputPort,
    output logic                  outputStrobe
);

    // control layout: jumpI 8, jumpR 7, aluSrc 6, branch 5, memRead 4,
    // memWrite 3, memToReg 2, regWrite 1, wwd 0
    logic [8:0]                idCtrl;
    logic [`WORD_SIZE-1:0]     pc, pcPlus1, nextPc;
    logic [`WORD_SIZE-1:0]     ifIdPc;
    logic                      ifIdBubble;

    logic [`WORD_SIZE-1:0]     idExPc, idExRsVal, idExRtVal, idExImm;
    logic [`REG_ADDR_BITS-1:0] idExRs, idExRt, idExRd;
    logic [3:0]                idExAluOp;
    logic [8:0]                idExCtrl;
    logic                      idExLhi, idExHalt, idExBubble;

    logic [`WORD_SIZE-1:0]     exMemResult, exMemStore;
    logic [`REG_ADDR_BITS-1:0] exMemRd;
    logic [4:0]                exMemCtrl;
    logic                      exMemHalt, exMemBubble;

    logic [`WORD_SIZE-1:0]     memWbResult, memWbLoad;
    logic [`REG_ADDR_BITS-1:0] memWbRd;
    logic [2:0]                memWbCtrl;
    logic                      memWbHalt, memWbBubble;

    logic                      freeze, idValid, idUseRs, idUseRt, idJump, stall, loadIdEx;
    logic [`REG_ADDR_BITS-1:0] idRd;
    logic [`WORD_SIZE-1:0]     idRsVal, idRtVal, idImm;
    logic [3:0]                idAluOp;

    logic [1:0]                forwardA, forwardB;
    logic [`WORD_SIZE-1:0]     rsFwd, rtFwd, aluB, aluResult, exResult, exTarget, wbData;
    logic                      branchTaken, exLink, exRedirect;

    function automatic logic [`WORD_SIZE-1:0] pickOperand(input logic [1:0] sel,
                                                          input logic [`WORD_SIZE-1:0] regVal,
                                                          input logic [`WORD_SIZE-1:0] memVal,
                                                          input logic [`WORD_SIZE-1:0] wbVal);
        case (sel)
            2'd1: return memVal;
            2'd2: return wbVal;
            default: return regVal;
        endcase
    endfunction

    // an HLT in flight squashes everything younger and stops fetch
    assign freeze = halted || idExHalt || exMemHalt || memWbHalt;
    assign idValid = !ifIdBubble && !freeze;
    assign idUseRs = idValid && useRs;
    assign idUseRt = idValid && useRt;
    assign idJump = idValid && isJumpI;
    assign loadIdEx = idValid && !exRedirect && !stall;
    assign idCtrl = {isJumpI, isJumpR, aluSrc, isBranch, memRead, memWrite, memToReg,
                     regWrite, wwd};

    // JAL and JRL link into register 2
    assign idRd = ((isJumpI || isJumpR) && regWrite) ? `REG_ADDR_BITS'd2 :
                  regDst ? idInstr.r.rd : idInstr.r.rt;

    always_comb begin
        case (idInstr.i.opcode)
            opLhi: idImm = {idInstr.i.imm, 8'h00};
            opOri: idImm = {8'h00, idInstr.i.imm};
            default: idImm = {{8{idInstr.i.imm[7]}}, idInstr.i.imm};
        endcase
    end

    always_comb begin
        if (isBranch) begin
            idAluOp = aluOpBne + idInstr.i.opcode;
        end else if (isAlu) begin
            idAluOp = idInstr.r.func[3:0];
        end else begin
            idAluOp = (idInstr.i.opcode == opOri) ? aluOpOr : aluOpAdd;
        end
    end

    assign rsFwd = pickOperand(forwardA, idExRsVal, exMemResult, wbData);
    assign rtFwd = pickOperand(forwardB, idExRtVal, exMemResult, wbData);
    // WWD passes rs through as rs + 0
    assign aluB = idExCtrl[0] ? '0 : idExCtrl[6] ? idExImm : rtFwd;

    assign exLink = (idExCtrl[8] || idExCtrl[7]) && idExCtrl[1];
    assign exResult = exLink ? idExPc : idExLhi ? idExImm : aluResult;
    assign exRedirect = (idExCtrl[5] && branchTaken) || idExCtrl[7];
    assign exTarget = idExCtrl[7] ? rsFwd : idExPc + idExImm;

    assign pcPlus1 = pc + 1'b1;
    assign nextPc = freeze     ? pc :
                    exRedirect ? exTarget :
                    stall      ? pc :
                    idJump     ? {ifIdPc[`WORD_SIZE-1:12], idInstr.j.target} :
                    pcPlus1;

    assign readM1 = !halted;
    assign address1 = pc;
    assign readM2 = exMemCtrl[4];
    assign writeM2 = exMemCtrl[3];
    assign address2 = exMemResult;
    assign writeData = exMemStore;
    assign wbData = memWbCtrl[2] ? memWbLoad : memWbResult;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `PC_RESET;
            ifIdBubble <= 1'b1;
            idExBubble <= 1'b1;
            idExCtrl <= '0;
            idExHalt <= 1'b0;
            exMemBubble <= 1'b1;
            exMemCtrl <= '0;
            exMemHalt <= 1'b0;
            memWbBubble <= 1'b1;
            memWbCtrl <= '0;
            memWbHalt <= 1'b0;
            halted <= 1'b0;
            numInst <= '0;
            outputPort <= '0;
            outputStrobe <= 1'b0;
        end else begin
            pc <= nextPc;
            if (freeze || exRedirect || idJump) begin
                ifIdBubble <= 1'b1;
            end else if (!stall) begin
                ifIdBubble <= 1'b0;
            end
            idExBubble <= !loadIdEx;
            idExCtrl <= loadIdEx ? idCtrl : '0;
            idExHalt <= loadIdEx && isHalt;
            exMemBubble <= idExBubble;
            exMemCtrl <= idExCtrl[4:0];
            exMemHalt <= idExHalt;
            memWbBubble <= exMemBubble;
            memWbCtrl <= exMemCtrl[2:0];
            memWbHalt <= exMemHalt;
            // retire
            outputStrobe <= !memWbBubble && memWbCtrl[0];
            if (!memWbBubble) begin
                numInst <= numInst + 1'b1;
                if (memWbCtrl[0]) begin
                    outputPort <= wbData;
                end
                if (memWbHalt) begin
                    halted <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!stall) begin
            idInstr <= data1;
            ifIdPc <= pcPlus1;
        end
        idExPc <= ifIdPc;
        idExRsVal <= idRsVal;
        idExRtVal <= idRtVal;
        idExImm <= idImm;
        idExRs <= idInstr.r.rs;
        idExRt <= idInstr.r.rt;
        idExRd <= idRd;
        idExAluOp <= idAluOp;
        idExLhi <= (idInstr.i.opcode == opLhi);
        exMemResult <= exResult;
        exMemStore <= rtFwd;
        exMemRd <= idExRd;
        memWbResult <= exMemResult;
        memWbLoad <= readData;
        memWbRd <= exMemRd;
    end

    registerFile uRegFile (
        .Clk      (Clk),
        .rstN     (rstN),
        .readAddr1(idInstr.r.rs),
        .readAddr2(idInstr.r.rt),
        .writeAddr(memWbRd),
        .writeData(wbData),
        .writeEn  (memWbCtrl[1]),
        .readData1(idRsVal),
        .readData2(idRtVal)
    );

    alu uAlu (
        .a          (rsFwd),
        .b          (aluB),
        .op         (idExAluOp),
        .result     (aluResult),
        .branchTaken(branchTaken)
    );

    hazardUnit uHazard (
        .idRs       (idInstr.r.rs),
        .idRt       (idInstr.r.rt),
        .useRs      (idUseRs),
        .useRt      (idUseRt),
        .exRs       (idExRs),
        .exRt       (idExRt),
        .exRd       (idExRd),
        .exMemRead  (idExCtrl[4]),
        .exIsJumpR  (idExCtrl[7]),
        .memRd      (exMemRd),
        .memRegWrite(exMemCtrl[1]),
        .wbRd       (memWbRd),
        .wbRegWrite (memWbCtrl[1]),
        .forwardA   (forwardA),
        .forwardB   (forwardB),
        .stall      (stall)
    );

    // one data port access per cycle
    memExclusive: assert property (@(posedge Clk) disable iff (!rstN) !(readM2 && writeM2));

    pcFrozen: assert property (@(posedge Clk) disable iff (!rstN) halted |=> $stable(pc));

endmodule

/* rtl/cpuTop.sv */
`include "cpu_config.svh"

module cpuTop import cpuPkg::*; (
    input  logic                  Clk,
    input  logic                  rstN,
    output logic                  readM1,
    output logic [`WORD_SIZE-1:0] address1,
    input  logic [`WORD_SIZE-1:0] data1,
    output logic                  readM2,
    output logic                  writeM2,
    output logic [`WORD_SIZE-1:0] address2,
    output logic [`WORD_SIZE-1:0] writeData,
    input  logic [`WORD_SIZE-1:0] readData,
    output logic                  halted,
    output logic [`WORD_SIZE-1:0] numInst,
    output logic [`WORD_SIZE-1:0] outputPort,
    output logic                  outputStrobe
);

    instrWord idInstr;
    logic     regDst, isJumpI, isJumpR, isAlu, aluSrc, isBranch, memRead;
    logic     memWrite, memToReg, regWrite, wwd, isHalt, useRs, useRt;

    datapath uDatapath (.*);

    // decodes the instruction held in IF/ID
    instrDecoder uDecoder (
        .instr(idInstr),
        .*
    );

endmodule

/* sim/cpuTb.sv */
`include "cpu_config.svh"

module cpuTb import cpuPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HaltTimeout = 2000;

    logic                  Clk;
    logic                  rstN;
    logic                  readM1, readM2, writeM2, halted, outputStrobe;
    logic [`WORD_SIZE-1:0] address1, data1, address2, writeData, readData;
    logic [`WORD_SIZE-1:0] numInst, outputPort;

    logic [`WORD_SIZE-1:0] mem [256];
    logic [`WORD_SIZE-1:0] refMem [256];
    logic [`WORD_SIZE-1:0] expOut [$];
    int                    expLoads;
    int                    readCount;
    int                    loadAddr;
    int                    outIdx;
    int                    testErrs;
    int                    testsPassed;
    int                    testsFailed;
    string                 testName;

    cpuTop UUT (.*);

    // one memory serves both ports, reads are combinational
    assign data1 = mem[address1[7:0]];
    assign readData = mem[address2[7:0]];

    always #10 Clk = ~Clk;

    always @(posedge Clk) begin
        if (writeM2) begin
            mem[address2[7:0]] <= writeData;
        end
    end

    // data port reads are counted, each strobe is compared with the next reference value
    always @(negedge Clk) begin
        if (rstN && readM2) begin
            readCount++;
        end
        if (rstN && outputStrobe) begin
            if (outIdx < expOut.size()) begin
                assert (outputPort == expOut[outIdx]) else begin
                    $display("error: test %s output %0d expected %h actual %h",
                             testName, outIdx, expOut[outIdx], outputPort);
                    testErrs++;
                end
            end else begin
                $display("error: test %s wrote more values than the reference", testName);
                testErrs++;
            end
            outIdx++;
        end
    end

    function automatic logic [15:0] rType(input logic [5:0] fn, input logic [1:0] rs, rt, rd);
        return {opRtype, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] iType(input logic [3:0] op, input logic [1:0] rs, rt,
                                          input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] jType(input logic [3:0] op, input logic [11:0] target);
        return {op, target};
    endfunction

    // sequential model of the instruction set, runs on refMem
    function automatic int interpretProgram();
        logic [15:0] regs [4];
        logic [15:0] pc, imm, ea, link;
        instrWord    ins;
        int          count;
        bit          done;
        foreach (regs[r]) begin
            regs[r] = '0;
        end
        pc = `PC_RESET;
        count = 0;
        done = 1'b0;
        expOut.delete();
        expLoads = 0;
        while (!done && count < 5000) begin
            ins = refMem[pc[7:0]];
            imm = {{8{ins.i.imm[7]}}, ins.i.imm};
            ea = regs[ins.i.rs] + imm;
            pc = pc + 1'b1;
            count++;
            case (ins.r.opcode)
                opBne: if (regs[ins.i.rs] != regs[ins.i.rt]) pc = pc + imm;
                opBeq: if (regs[ins.i.rs] == regs[ins.i.rt]) pc = pc + imm;
                opBgz: if ($signed(regs[ins.i.rs]) > 0) pc = pc + imm;
                opBlz: if ($signed(regs[ins.i.rs]) < 0) pc = pc + imm;
                opAdi: regs[ins.i.rt] = regs[ins.i.rs] + imm;
                opOri: regs[ins.i.rt] = regs[ins.i.rs] | {8'h00, ins.i.imm};
                opLhi: regs[ins.i.rt] = {ins.i.imm, 8'h00};
                opLwd: begin
                    regs[ins.i.rt] = refMem[ea[7:0]];
                    expLoads++;
                end
                opSwd: refMem[ea[7:0]] = regs[ins.i.rt];
                opJmp: pc = {pc[15:12], ins.j.target};
                opJal: begin
                    regs[2] = pc;
                    pc = {pc[15:12], ins.j.target};
                end
                opRtype: begin
                    case (ins.r.func)
                        fnAdd: regs[ins.r.rd] = regs[ins.r.rs] + regs[ins.r.rt];
                        fnSub: regs[ins.r.rd] = regs[ins.r.rs] - regs[ins.r.rt];
                        fnAnd: regs[ins.r.rd] = regs[ins.r.rs] & regs[ins.r.rt];
                        fnOrr: regs[ins.r.rd] = regs[ins.r.rs] | regs[ins.r.rt];
                        fnNot: regs[ins.r.rd] = ~regs[ins.r.rs];
                        fnTcp: regs[ins.r.rd] = -regs[ins.r.rs];
                        fnShl: regs[ins.r.rd] = regs[ins.r.rs] << 1;
                        fnShr: regs[ins.r.rd] = $signed(regs[ins.r.rs]) >>> 1;
                        fnWwd: expOut.push_back(regs[ins.r.rs]);
                        fnJpr: pc = regs[ins.r.rs];
                        fnJrl: begin
                            link = pc;
                            pc = regs[ins.r.rs];
                            regs[2] = link;
                        end
                        fnHlt: done = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
        return count;
    endfunction

    task automatic putWord(input logic [15:0] w);
        mem[loadAddr[7:0]] = w;
        loadAddr++;
    endtask

    task automatic loadConst(input logic [1:0] r, input logic [15:0] v);
        putWord(iType(opLhi, 2'd0, r, v[15:8]));
        putWord(iType(opOri, r, r, v[7:0]));
    endtask

    task automatic holdReset();
        @(posedge Clk);
        rstN <= 1'b0;
        @(negedge Clk);
        foreach (mem[a]) begin
            mem[a] = {8'(~a), 8'(a)};
        end
        loadAddr = 0;
    endtask

    task automatic buildArith();
        logic [5:0] aluFns [8];
        aluFns = '{fnAdd, fnSub, fnAnd, fnOrr, fnNot, fnTcp, fnShl, fnShr};
        // negative r0 so SHR has to keep the sign
        loadConst(2'd0, 16'($urandom) | 16'h8000);
        loadConst(2'd1, 16'($urandom));
        foreach (aluFns[k]) begin
            putWord(rType(aluFns[k], 2'd0, 2'd1, 2'd2));
            putWord(rType(fnWwd, 2'd2, 2'd0, 2'd0));
        end
        putWord(iType(opAdi, 2'd0, 2'd3, 8'($urandom)));
        putWord(rType(fnWwd, 2'd3, 2'd0, 2'd0));
        putWord(iType(opOri, 2'd1, 2'd3, 8'($urandom)));
        putWord(rType(fnWwd, 2'd3, 2'd0, 2'd0));
        putWord(iType(opLhi, 2'd0, 2'd3, 8'($urandom)));
        putWord(rType(fnWwd, 2'd3, 2'd0, 2'd0));
        putWord(rType(fnHlt, 2'd0, 2'd0, 2'd0));
    endtask

    task automatic buildMemory();
        logic [7:0] offs [4];
        // data area starts at 0xc0, well past the program
        loadConst(2'd0, 16'h00C0);
        foreach (offs[k]) begin
            offs[k] = 8'($urandom % 64);
            loadConst(2'd1, 16'($urandom));
            putWord(iType(opSwd, 2'd0, 2'd1, offs[k]));
            putWord(iType(opLwd, 2'd0, 2'd2, offs[k]));
            putWord(rType(fnWwd, 2'd2, 2'd0, 2'd0));
        end
        foreach (offs[k]) begin
            putWord(iType(opLwd, 2'd0, 2'd3, offs[k]));
            putWord(rType(fnWwd, 2'd3, 2'd0, 2'd0));
        end
        putWord(rType(fnHlt, 2'd0, 2'd0, 2'd0));
    endtask

    task automatic buildControl();
        putWord(iType(opAdi, 2'd0, 2'd0, 8'd5));
        putWord(iType(opAdi, 2'd1, 2'd1, 8'd5));
        putWord(iType(opAdi, 2'd3, 2'd3, 8'hFD));
        // addresses 3 to 14, each branch skips one WWD when taken
        putWord(iType(opBne, 2'd0, 2'd1, 8'd1));
        putWord(rType(fnWwd, 2'd0, 2'd0, 2'd0));
        putWord(iType(opBeq, 2'd0, 2'd1, 8'd1));
        putWord(rType(fnWwd, 2'd3, 2'd0, 2'd0));
        putWord(iType(opBgz, 2'd0, 2'd0, 8'd1));
        putWord(rType(fnWwd, 2'd3, 2'd0, 2'd0));
        putWord(iType(opBlz, 2'd0, 2'd0, 8'd1));
        putWord(rType(fnWwd, 2'd1, 2'd0, 2'd0));
        putWord(iType(opBlz, 2'd3, 2'd0, 8'd1));
        putWord(rType(fnWwd, 2'd0, 2'd0, 2'd0));
        putWord(iType(opBgz, 2'd3, 2'd0, 8'd1));
        putWord(rType(fnWwd, 2'd3, 2'd0, 2'd0));
        // 15: jump over 16, JAL at 17 links 18
        putWord(jType(opJmp, 12'd17));
        putWord(rType(fnWwd, 2'd0, 2'd0, 2'd0));
        putWord(jType(opJal, 12'd20));
        putWord(jType(opJmp, 12'd24));
        putWord(rType(fnHlt, 2'd0, 2'd0, 2'd0));
        putWord(rType(fnWwd, 2'd2, 2'd0, 2'd0));
        putWord(rType(fnJpr, 2'd2, 2'd0, 2'd0));
        putWord(rType(fnWwd, 2'd0, 2'd0, 2'd0));
        putWord(rType(fnWwd, 2'd0, 2'd0, 2'd0));
        // 24: JRL at 26 goes to 28 and links 27
        putWord(iType(opLhi, 2'd0, 2'd1, 8'd0));
        putWord(iType(opAdi, 2'd1, 2'd1, 8'd28));
        putWord(rType(fnJrl, 2'd1, 2'd0, 2'd0));
        putWord(rType(fnWwd, 2'd0, 2'd0, 2'd0));
        putWord(rType(fnWwd, 2'd2, 2'd0, 2'd0));
        putWord(rType(fnHlt, 2'd0, 2'd0, 2'd0));
    endtask

    task automatic buildHazard();
        loadConst(2'd0, 16'($urandom));
        loadConst(2'd1, 16'($urandom));
        putWord(rType(fnAdd, 2'd0, 2'd1, 2'd2));
        putWord(rType(fnSub, 2'd2, 2'd0, 2'd3));
        putWord(rType(fnAnd, 2'd3, 2'd2, 2'd1));
        putWord(rType(fnOrr, 2'd1, 2'd3, 2'd0));
        putWord(rType(fnWwd, 2'd0, 2'd0, 2'd0));
        loadConst(2'd2, 16'h00E0);
        putWord(iType(opSwd, 2'd2, 2'd0, 8'd0));
        // load then immediate use, once as ALU operand and once as store data
        putWord(iType(opLwd, 2'd2, 2'd3, 8'd0));
        putWord(rType(fnAdd, 2'd3, 2'd3, 2'd1));
        putWord(rType(fnWwd, 2'd1, 2'd0, 2'd0));
        putWord(iType(opLwd, 2'd2, 2'd0, 8'd0));
        putWord(iType(opSwd, 2'd2, 2'd0, 8'd1));
        putWord(iType(opLwd, 2'd2, 2'd1, 8'd1));
        putWord(rType(fnWwd, 2'd1, 2'd0, 2'd0));
        // countdown loop from 3 with a backward branch
        loadConst(2'd3, 16'd3);
        putWord(iType(opAdi, 2'd3, 2'd3, 8'hFF));
        putWord(rType(fnWwd, 2'd3, 2'd0, 2'd0));
        putWord(iType(opBgz, 2'd3, 2'd0, 8'hFD));
        putWord(rType(fnHlt, 2'd0, 2'd0, 2'd0));
    endtask

    task automatic buildHalt();
        putWord(iType(opAdi, 2'd0, 2'd0, 8'd7));
        putWord(rType(fnWwd, 2'd0, 2'd0, 2'd0));
        putWord(rType(fnHlt, 2'd0, 2'd0, 2'd0));
        // never executes
        putWord(rType(fnWwd, 2'd0, 2'd0, 2'd0));
        putWord(iType(opAdi, 2'd0, 2'd0, 8'd1));
    endtask

    task automatic closeTest(input string name, input int instCount);
        $display("test %s: %s, %0d outputs, %0d instructions", name,
                 (testErrs == 0) ? "pass" : "fail", outIdx, instCount);
        if (testErrs == 0) begin
            testsPassed++;
        end else begin
            testsFailed++;
        end
    endtask

    task automatic runProgram(input string name);
        int                    expCount;
        int                    cycles;
        logic [`WORD_SIZE-1:0] finalCount;
        testName = name;
        testErrs = 0;
        outIdx = 0;
        readCount = 0;
        refMem = mem;
        expCount = interpretProgram();
        repeat (2) @(posedge Clk);
        rstN <= 1'b1;
        cycles = 0;
        while (!halted && cycles < HaltTimeout) begin
            @(negedge Clk);
            cycles++;
        end
        if (!halted) begin
            $display("error: test %s did not halt within %0d cycles", name, HaltTimeout);
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            assert (numInst == `WORD_SIZE'(expCount)) else begin
                $display("error: test %s numInst expected %0d actual %0d",
                         name, expCount, numInst);
                testErrs++;
            end
            finalCount = numInst;
            repeat (20) begin
                @(negedge Clk);
                assert (numInst == finalCount) else begin
                    $display("error: test %s numInst after halt expected %0d actual %0d",
                             name, finalCount, numInst);
                    testErrs++;
                end
                assert (!readM1) else begin
                    $display("error: test %s still fetches while halted", name);
                    testErrs++;
                end
            end
            foreach (mem[a]) begin
                assert (mem[a] == refMem[a]) else begin
                    $display("error: test %s mem[%02h] expected %h actual %h",
                             name, a, refMem[a], mem[a]);
                    testErrs++;
                end
            end
            assert (outIdx == expOut.size()) else begin
                $display("error: test %s output count expected %0d actual %0d",
                         name, expOut.size(), outIdx);
                testErrs++;
            end
            // one data port read per executed load
            assert (readCount == expLoads) else begin
                $display("error: test %s data reads expected %0d actual %0d",
                         name, expLoads, readCount);
                testErrs++;
            end
            closeTest(name, expCount);
        end
    endtask

    // reset while halted must clear the retirement state at once
    task automatic checkCleared();
        testName = "reset";
        testErrs = 0;
        outIdx = 0;
        @(posedge Clk);
        rstN <= 1'b0;
        @(negedge Clk);
        assert (halted == 1'b0) else begin
            $display("error: test reset halted expected 0 actual %b", halted);
            testErrs++;
        end
        assert (numInst == '0) else begin
            $display("error: test reset numInst expected 0 actual %0d", numInst);
            testErrs++;
        end
        assert (outputPort == '0) else begin
            $display("error: test reset outputPort expected 0000 actual %h", outputPort);
            testErrs++;
        end
        closeTest("reset", 0);
    endtask

    initial begin
        Clk = 1'b0;
        rstN = 1'b0;
        void'($urandom(32'hbfd7));
        holdReset();
        buildArith();
        runProgram("arith");
        holdReset();
        buildMemory();
        runProgram("memory");
        holdReset();
        buildControl();
        runProgram("control");
        holdReset();
        buildHazard();
        runProgram("hazard");
        holdReset();
        buildHalt();
        runProgram("halt");
        checkCleared();
        $display("%0d tests run, %0d passed, %0d failed",
                 testsPassed + testsFailed, testsPassed, testsFailed);
        if (testsFailed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+rtl
rtl/cpuPkg.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/hazardUnit.sv
rtl/instrDecoder.sv
rtl/datapath.sv
rtl/cpuTop.sv
sim/cpuTb.sv
